// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       = cntTb
FILELIST  = sources.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
PASSMSG   = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// ==== sources.f ====
verilog/cntPkg.sv
verilog/clockSync.sv
verilog/refreshTimer.sv
verilog/ioQosTimer.sv
verilog/startupSeq.sv
verilog/cntTop.sv
tests/cntTb.sv

// ==== tests/cntTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cntTb;

	import cntPkg::*;

	// four refresh periods per long interval keeps startup short.
	localparam int unsigned LONG_LAST = 3;
	localparam int unsigned REF_LAST = REF_LAST_DEF;
	// CLK cycles per half E period.
	localparam int E_HALF = 10;
	localparam int RESET_CYCLES = 8;
	// extra E periods a wait may take before it gives up.
	localparam int WAIT_SLACK = 4;
	localparam int MAX_LINES = 1000;

	logic    CLK;
	logic    reset;
	logic    e;
	logic    c8m;
	logic    nIpl2;
	logic    nResIn;
	logic    bact;
	logic    bactR;
	qosSelT  qosSel;
	logic    refReq;
	logic    refUrg;
	busCtrlT busCtrl;
	logic    ioQosEn;
	logic    mcke;

	// c8m toggles every two CLK while running, else it sits high.
	logic        c8mRun;
	logic [1:0]  c8mCnt;
	// E falling edges since reset.
	int unsigned eFalls;
	// outputs captured at the last rising edge of E.
	busCtrlT     busSeen;
	logic        reqSeen;
	logic        urgSeen;
	logic        qosSeen;
	logic        mckeSeen;

	cntTop #(
		.LONG_LAST (LONG_LAST)
	) u_cntTop (
		.CLK     (CLK),
		.reset   (reset),
		.e       (e),
		.c8m     (c8m),
		.nIpl2   (nIpl2),
		.nResIn  (nResIn),
		.bact    (bact),
		.bactR   (bactR),
		.qosSel  (qosSel),
		.refReq  (refReq),
		.refUrg  (refUrg),
		.busCtrl (busCtrl),
		.ioQosEn (ioQosEn),
		.mcke    (mcke)
	);

	always #20 CLK = ~CLK;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkBusCtrl(input busCtrlT got, input busCtrlT exp);
		if (got !== exp) begin
			abortRun($sformatf("ERR %0t: busCtrl is %b, expected %b", $time, got, exp));
		end
	endtask

	task automatic checkRefresh(input logic gotReq, gotUrg, expReq, expUrg);
		if (gotReq !== expReq || gotUrg !== expUrg) begin
			abortRun($sformatf("ERR %0t: refReq/refUrg are %b%b, expected %b%b after %0d E falls",
				$time, gotReq, gotUrg, expReq, expUrg, eFalls));
		end
	endtask

	task automatic checkQos(input logic gotEn, gotMcke, expEn, expMcke);
		if (gotEn !== expEn || gotMcke !== expMcke) begin
			abortRun($sformatf("ERR %0t: ioQosEn/mcke are %b%b, expected %b%b",
				$time, gotEn, gotMcke, expEn, expMcke));
		end
	endtask

	// reference refresh levels, counted back from the idle period.
	// one period in each refresh period has no request, the two before it are urgent.
	task automatic expectRefresh();
		int unsigned pos;
		int unsigned toIdle;
		logic expReq;
		logic expUrg;
		expReq = 1'b0;
		expUrg = 1'b0;
		if (eFalls != 0) begin
			pos = (eFalls - 1) % (REF_LAST + 1);
			// E periods left until the one without a request.
			toIdle = REF_LAST - pos;
			expReq = toIdle != 0;
			expUrg = toIdle == 1 || toIdle == 2;
		end
		checkRefresh(reqSeen, urgSeen, expReq, expUrg);
	endtask

	// one CLK, inputs change on the falling edge.
	task automatic stepClk();
		@(negedge CLK);
		bactR = bact;
		c8mCnt = c8mCnt + 2'd1;
		c8m = c8mRun ? c8mCnt[1] : 1'b1;
	endtask

	task automatic sampleOutputs();
		busSeen = busCtrl;
		reqSeen = refReq;
		urgSeen = refUrg;
		qosSeen = ioQosEn;
		mckeSeen = mcke;
	endtask

	// E falls at the start, outputs are read when it rises again.
	task automatic runEPeriod();
		e = 1'b0;
		eFalls++;
		repeat (E_HALF) stepClk();
		e = 1'b1;
		sampleOutputs();
		expectRefresh();
		repeat (E_HALF) stepClk();
	endtask

	// run E periods until the host reset is released.
	task automatic waitResetRelease(input int expPeriods);
		int count;
		count = 0;
		while (!busSeen.nResOut && count < expPeriods + WAIT_SLACK) begin
			runEPeriod();
			count++;
		end
		if (!busSeen.nResOut) begin
			abortRun($sformatf("nResOut never rose within %0d E periods", count));
		end else if (count + 1 < expPeriods || count > expPeriods + 1) begin
			abortRun($sformatf("ERR %0t: nResOut rose after %0d E periods, expected %0d",
				$time, count, expPeriods));
		end
	endtask

	// one bus cycle after a random idle gap.
	task automatic runBusCycle(input qosSelT sel);
		int unsigned gap;
		gap = 1 + ($urandom % 4);
		repeat (gap) stepClk();
		bact = 1'b1;
		qosSel = sel;
		repeat (2) stepClk();
		bact = 1'b0;
		qosSel = '0;
		stepClk();
	endtask

	task automatic runTrace(input int fd);
		string line;
		byte op;
		int lineNo;
		int num;
		int lvl;
		logic [2:0] bits;
		for (lineNo = 1; lineNo <= MAX_LINES && !$feof(fd); lineNo++) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			num = 0;
			lvl = 0;
			bits = '0;
			void'($sscanf(line, "%c %d %d", op, num, lvl));
			case (op)
				"E": repeat (num) runEPeriod();
				"W": waitResetRelease(num);
				"C": c8mRun = num[0];
				"N": nIpl2 = num[0];
				"R": nResIn = num[0];
				"B": bact = num[0];
				"Q": checkQos(qosSeen, mckeSeen, num[0], lvl[0]);
				"S": begin
					void'($sscanf(line, "%c %b", op, bits));
					runBusCycle(qosSelT'(bits));
				end
				"X": begin
					void'($sscanf(line, "%c %b", op, bits));
					checkBusCtrl(busSeen, busCtrlT'(bits));
				end
				default: abortRun($sformatf("unknown command on trace line %0d", lineNo));
			endcase
		end
	endtask

	initial begin
		int fd;
		CLK = 1'b0;
		reset = 1'b1;
		e = 1'b1;
		c8m = 1'b1;
		nIpl2 = 1'b1;
		nResIn = 1'b1;
		bact = 1'b0;
		bactR = 1'b0;
		qosSel = '0;
		c8mRun = 1'b1;
		c8mCnt = 2'd0;
		eFalls = 0;
		void'($urandom(32'hd6dc));
		repeat (RESET_CYCLES) stepClk();
		reset = 1'b0;
		// E stays high a few CLK so the synchronizer settles.
		repeat (4) stepClk();
		sampleOutputs();
		// no refresh request and no urgency before the first E fall.
		expectRefresh();
		fd = $fopen("tests/cntTrace.txt", "r");
		if (fd == 0) begin
			abortRun("cannot open the trace file tests/cntTrace.txt");
		end else begin
			runTrace(fd);
			$fclose(fd);
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tests/cntTrace.txt ====
# op arg: E n E periods, W n periods until nResOut rises, C c8m runs, N nIpl2, R nResIn, B bact,
# S ioQosCs/sndQosCs/iackCs, X expected aoutOe/nBrIob/nResOut, Q expected ioQosEn and mcke
X 000
Q 0 1
E 87
X 000
E 1
X 100   # phase 2 drives the bus
W 44
X 101
E 1     # watcher arms
R 0
E 1
X 000
R 1
E 46
N 0
E 1
X 010   # nmi drops the bus request
E 49
X 010   # held nmi stalls phase 1
N 1
W 78
X 011
E 1
R 0
E 1
X 000
R 1
E 86
X 100
W 44
X 101
E 44    # priority window from the button has run out
C 0
Q 0 1
S 100
E 1
Q 1 0
B 1
E 1
Q 1 1
B 0
S 010
E 1
Q 1 0
E 176
Q 0 1

// ==== verilog/clockSync.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockSync (
	input  logic           CLK,
	input  logic           reset,
	input  logic           e,
	input  logic           c8m,
	input  logic           nIpl2,
	input  logic           nResIn,
	output cntPkg::syncInT syncIn
);

	// sample history of the slow clocks.
	// bit 0 holds the newest sample.
	logic [1:0] eHist;
	logic [1:0] c8mHist;

	// first stage, shift in the raw pins.
	// cleared low so a high pin after reset never looks like a fall.
	always_ff @(posedge CLK) begin
		if (reset) begin
			eHist <= 2'b00;
			c8mHist <= 2'b00;
		end else begin
			eHist <= {eHist[0], e};
			c8mHist <= {c8mHist[0], c8m};
		end
	end

	// second stage, registered strobes and button levels.
	always_ff @(posedge CLK) begin
		if (reset) begin
			syncIn.eFall <= 1'b0;
			syncIn.c8mFall <= 1'b0;
			// buttons read as released.
			syncIn.nIpl2 <= 1'b1;
			syncIn.nRes <= 1'b1;
		end else begin
			// high then low in the history is a falling edge.
			syncIn.eFall <= eHist[1] && !eHist[0];
			syncIn.c8mFall <= c8mHist[1] && !c8mHist[0];
			// buttons are slow, one register is enough.
			syncIn.nIpl2 <= nIpl2;
			syncIn.nRes <= nResIn;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cntPkg.sv ====
`default_nettype none

package cntPkg;

	// host inputs after synchronization into the CLK domain.
	// the two strobes are high for one CLK on a falling edge.
	typedef struct packed {
		// nmi button, low while pressed.
		logic nIpl2;
		// reset button, low while pressed.
		logic nRes;
		logic eFall;
		logic c8mFall;
	} syncInT;

	// timing strobes from the refresh and long timers.
	typedef struct packed {
		// end of one refresh period.
		logic periodEnd;
		// end of one long interval, a subset of periodEnd.
		logic longEnd;
		// one strobe per E period.
		logic eTick;
	} tickT;

	// host bus control, all registered.
	typedef struct packed {
		// drive PDS address and control.
		logic aoutOe;
		// bus request, active low.
		logic nBrIob;
		// host reset, active low.
		logic nResOut;
	} busCtrlT;

	// chip selects that start the i/o priority window.
	typedef struct packed {
		logic ioQosCs;
		logic sndQosCs;
		logic iackCs;
	} qosSelT;

	// refresh counter runs 0..10, so 11 E periods per refresh.
	localparam int unsigned REF_LAST_DEF = 10;
	// urgency covers the last two counts before the idle period.
	localparam int unsigned REF_URG_FROM_DEF = 9;
	// long timer length in refresh periods, minus one.
	localparam int unsigned LONG_LAST_DEF = 2047;
	// i/o priority hold time in refresh periods.
	localparam int unsigned QOS_HOLD_DEF = 15;

endpackage

`default_nettype wire

// ==== verilog/cntTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cntTop #(
	parameter int unsigned REF_LAST     = cntPkg::REF_LAST_DEF,
	parameter int unsigned REF_URG_FROM = cntPkg::REF_URG_FROM_DEF,
	parameter int unsigned LONG_LAST    = cntPkg::LONG_LAST_DEF,
	parameter int unsigned QOS_HOLD     = cntPkg::QOS_HOLD_DEF
) (
	input  logic            CLK,
	input  logic            reset,
	input  logic            e,
	input  logic            c8m,
	input  logic            nIpl2,
	input  logic            nResIn,
	input  logic            bact,
	input  logic            bactR,
	input  cntPkg::qosSelT  qosSel,
	output logic            refReq,
	output logic            refUrg,
	output cntPkg::busCtrlT busCtrl,
	output logic            ioQosEn,
	output logic            mcke
);

	import cntPkg::*;

	// synchronized inputs, shared by the three timing blocks.
	syncInT syncIn;
	// period and interval strobes.
	tickT   tick;

	clockSync u_clockSync (
		.CLK    (CLK),
		.reset  (reset),
		.e      (e),
		.c8m    (c8m),
		.nIpl2  (nIpl2),
		.nResIn (nResIn),
		.syncIn (syncIn)
	);

	refreshTimer #(
		.REF_LAST     (REF_LAST),
		.REF_URG_FROM (REF_URG_FROM),
		.LONG_LAST    (LONG_LAST)
	) u_refreshTimer (
		.CLK    (CLK),
		.reset  (reset),
		.syncIn (syncIn),
		.tick   (tick),
		.refReq (refReq),
		.refUrg (refUrg)
	);

	ioQosTimer #(
		.QOS_HOLD (QOS_HOLD)
	) u_ioQosTimer (
		.CLK     (CLK),
		.reset   (reset),
		.syncIn  (syncIn),
		.tick    (tick),
		.bact    (bact),
		.bactR   (bactR),
		.qosSel  (qosSel),
		.ioQosEn (ioQosEn),
		.mcke    (mcke)
	);

	startupSeq u_startupSeq (
		.CLK     (CLK),
		.reset   (reset),
		.syncIn  (syncIn),
		.tick    (tick),
		.busCtrl (busCtrl)
	);

endmodule

`default_nettype wire

// ==== verilog/ioQosTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ioQosTimer #(
	parameter int unsigned QOS_HOLD = cntPkg::QOS_HOLD_DEF
) (
	input  logic           CLK,
	input  logic           reset,
	input  cntPkg::syncInT syncIn,
	input  cntPkg::tickT   tick,
	input  logic           bact,
	input  logic           bactR,
	input  cntPkg::qosSelT qosSel,
	output logic           ioQosEn,
	output logic           mcke
);

	localparam int unsigned QOS_W = (QOS_HOLD > 0) ? $clog2(QOS_HOLD + 1) : 1;
	localparam logic [QOS_W-1:0] QOS_RELOAD = QOS_W'(QOS_HOLD);

	logic             iackSel;
	logic             ioSel;
	logic [QOS_W-1:0] qosCnt;

	// registered selects, only valid during a bus cycle.
	// a pressed reset button counts as an interrupt acknowledge.
	always_ff @(posedge CLK) begin
		if (reset) begin
			iackSel <= 1'b0;
			ioSel <= 1'b0;
		end else begin
			iackSel <= (bact && qosSel.iackCs) || !syncIn.nRes;
			ioSel <= bact && (qosSel.ioQosCs || qosSel.sndQosCs);
		end
	end

	// countdown in refresh periods.
	// any select restarts the full hold time.
	always_ff @(posedge CLK) begin
		if (reset) begin
			qosCnt <= '0;
		end else if (iackSel || ioSel) begin
			qosCnt <= QOS_RELOAD;
		end else if (qosCnt != '0 && tick.periodEnd) begin
			qosCnt <= qosCnt - 1'b1;
		end
	end

	// priority level changes only between bus cycles.
	// the 68000 clock is throttled to C8M edges while it is set.
	always_ff @(posedge CLK) begin
		if (reset) begin
			ioQosEn <= 1'b0;
			mcke <= 1'b1;
		end else begin
			if (!bact) begin
				ioQosEn <= qosCnt != '0;
			end
			mcke <= bact || bactR || !ioQosEn || syncIn.c8mFall;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/refreshTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module refreshTimer #(
	parameter int unsigned REF_LAST     = cntPkg::REF_LAST_DEF,
	parameter int unsigned REF_URG_FROM = cntPkg::REF_URG_FROM_DEF,
	parameter int unsigned LONG_LAST    = cntPkg::LONG_LAST_DEF
) (
	input  logic           CLK,
	input  logic           reset,
	input  cntPkg::syncInT syncIn,
	output cntPkg::tickT   tick,
	output logic           refReq,
	output logic           refUrg
);

	// counter widths follow the terminal counts.
	localparam int unsigned REF_W  = (REF_LAST > 0) ? $clog2(REF_LAST + 1) : 1;
	localparam int unsigned LONG_W = (LONG_LAST > 0) ? $clog2(LONG_LAST + 1) : 1;

	// compare values, one count early since the flags are registered.
	localparam logic [REF_W-1:0]  REF_PRE  = REF_W'(REF_LAST - 1);
	localparam logic [REF_W-1:0]  REF_END  = REF_W'(REF_LAST);
	localparam logic [REF_W-1:0]  URG_LO   = REF_W'(REF_URG_FROM - 1);
	localparam logic [LONG_W-1:0] LONG_PRE = LONG_W'(LONG_LAST - 1);

	logic [REF_W-1:0]  refCnt;
	logic              refTc;
	logic [LONG_W-1:0] longCnt;
	logic              longTc;
	logic              periodEndNow;

	// last E edge of the refresh period.
	assign periodEndNow = syncIn.eFall && refTc;

	// short timer, one step per E period.
	// refReq drops for the period after the last count.
	// refUrg covers the two periods before that.
	always_ff @(posedge CLK) begin
		if (reset) begin
			refCnt <= '0;
			refTc <= 1'b0;
			refReq <= 1'b0;
			refUrg <= 1'b0;
		end else if (syncIn.eFall) begin
			refCnt <= refTc ? '0 : refCnt + 1'b1;
			refTc <= refCnt == REF_PRE;
			refReq <= refCnt != REF_END;
			refUrg <= (refCnt >= URG_LO) && (refCnt <= REF_PRE);
		end
	end

	// long timer, one step per refresh period.
	always_ff @(posedge CLK) begin
		if (reset) begin
			longCnt <= '0;
			longTc <= 1'b0;
		end else if (periodEndNow) begin
			longCnt <= longTc ? '0 : longCnt + 1'b1;
			longTc <= longCnt == LONG_PRE;
		end
	end

	// strobes to the other blocks, all delayed by the same one CLK.
	always_ff @(posedge CLK) begin
		if (reset) begin
			tick <= '0;
		end else begin
			tick.periodEnd <= periodEndNow;
			tick.longEnd <= periodEndNow && longTc;
			tick.eTick <= syncIn.eFall;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/startupSeq.sv ====
`timescale 1ns/1ps
`default_nettype none

module startupSeq (
	input  logic            CLK,
	input  logic            reset,
	input  cntPkg::syncInT  syncIn,
	input  cntPkg::tickT    tick,
	output cntPkg::busCtrlT busCtrl
);

	// startup phases.
	localparam logic [1:0] PH_HOLD    = 2'd0;
	localparam logic [1:0] PH_NMI     = 2'd1;
	localparam logic [1:0] PH_DRIVE   = 2'd2;
	localparam logic [1:0] PH_RUNNING = 2'd3;

	logic [1:0] phase;
	logic       lookReset;

	// reset button watcher.
	// arms one E period after reset release, so a button
	// still held from the last press is ignored.
	always_ff @(posedge CLK) begin
		if (reset) begin
			lookReset <= 1'b0;
		end else if (!busCtrl.nResOut) begin
			lookReset <= 1'b0;
		end else if (tick.eTick) begin
			lookReset <= 1'b1;
		end
	end

	// phase sequencing and bus control outputs.
	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= PH_HOLD;
			busCtrl.aoutOe <= 1'b0;
			busCtrl.nBrIob <= 1'b0;
			busCtrl.nResOut <= 1'b0;
		end else begin
			case (phase)
				PH_HOLD: begin
					// pds bus floated, host in reset, bus requested.
					busCtrl.aoutOe <= 1'b0;
					busCtrl.nBrIob <= 1'b0;
					busCtrl.nResOut <= 1'b0;
					if (tick.longEnd) begin
						phase <= PH_NMI;
					end
				end
				PH_NMI: begin
					busCtrl.aoutOe <= 1'b0;
					busCtrl.nResOut <= 1'b0;
					// nmi drops the request, and it stays dropped.
					busCtrl.nBrIob <= !(!busCtrl.nBrIob && syncIn.nIpl2);
					// wait here while the button is held.
					if (tick.longEnd && syncIn.nIpl2) begin
						phase <= PH_DRIVE;
					end
				end
				PH_DRIVE: begin
					// only drive the bus if it was requested.
					busCtrl.aoutOe <= !busCtrl.nBrIob;
					busCtrl.nResOut <= 1'b0;
					if (tick.longEnd) begin
						phase <= PH_RUNNING;
					end
				end
				default: begin
					// let the host run.
					busCtrl.nResOut <= 1'b1;
					if (lookReset && !syncIn.nRes) begin
						phase <= PH_HOLD;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire
